// File: compile.f
+incdir+hw
hw/scan_pkg.sv
hw/sprite_latch.sv
hw/scan_sequencer.sv
hw/frame_addr_map.sv
hw/frame_scan_top.sv
tests/frame_scan_chk.sv
tests/frame_scan_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the frame scan testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module frame_scan_tb \
    -o frame_scan_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/frame_scan_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// File: tests/frame_scan_tb.sv
// -----------------------------------------------
// frame scan testbench: raster and sprite stimulus
// with run control around the bound checker
// -----------------------------------------------
`timescale 1ns/1ps
`include "scan_cfg.svh"

module frame_scan_tb
    import scan_pkg::*;
();

    localparam int     CLK_NS       = 100;
    localparam int     DRIVE_NS     = 10;
    localparam int     FRAME_CYCLES = (`H_LAST + 1) * (`V_LAST + 1);
    localparam longint WATCHDOG_NS  = longint'(12) * FRAME_CYCLES * CLK_NS;

    logic        vgaclk;
    logic        rst;
    logic [9:0]  hc;
    logic [9:0]  vc;
    logic        write_enable;
    logic        scanall;
    sprite_set_t sprites;
    logic [8:0]  xpos;
    logic [8:0]  ypos;
    logic [15:0] address;
    logic [31:0] rng;
    int          frames_done;

    frame_scan_top dut_i (
        .vgaclk       (vgaclk),
        .rst          (rst),
        .hc           (hc),
        .vc           (vc),
        .write_enable (write_enable),
        .scanall      (scanall),
        .sprites      (sprites),
        .xpos         (xpos),
        .ypos         (ypos),
        .address      (address)
    );

    bind frame_scan_top frame_scan_chk chk_i (
        .vgaclk       (vgaclk),
        .rst          (rst),
        .hc           (hc),
        .vc           (vc),
        .write_enable (write_enable),
        .scanall      (scanall),
        .sprites      (sprites),
        .xpos         (xpos),
        .ypos         (ypos),
        .address      (address)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        logic [31:0] r;
        r = s;
        r = r ^ (r << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // x in 8..230, y in 8..310
    task automatic draw_sprites();
        for (int i = 0; i < `NUM_SPRITES; i++) begin
            rng = xorshift32(rng);
            sprites[i].x = 9'(8 + rng[15:0] % 223);
            sprites[i].y = 9'(8 + rng[31:16] % 303);
        end
    endtask

    task automatic advance_raster();
        @(posedge vgaclk);
        #(DRIVE_NS);
        if (hc != 10'(`H_LAST)) begin
            hc = hc + 10'd1;
        end else if (vc != 10'(`V_LAST)) begin
            hc = '0;
            vc = vc + 10'd1;
        end else begin
            // a frame end was just sampled
            hc = '0;
            vc = '0;
            write_enable = ~write_enable;
            draw_sprites();
            frames_done++;
        end
    endtask

    task automatic run_cycles(int n);
        for (int i = 0; i < n; i++) begin
            advance_raster();
        end
    endtask

    task automatic wait_frames(int n);
        int target;
        target = frames_done + n;
        while (frames_done < target) begin
            advance_raster();
        end
    endtask

    initial begin
        vgaclk = 1'b0;
        forever #(CLK_NS / 2) vgaclk = ~vgaclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Finished with errors");
        $fatal(1, "watchdog expired before the stimulus completed");
    end

    always @(negedge vgaclk) begin
        if (dut_i.chk_i.fail_count != 0) begin
            $display("Finished with errors");
            $fatal(1, "checker assertion failed");
        end
    end

    initial begin
        rst          = 1'b1;
        hc           = '0;
        vc           = '0;
        write_enable = 1'b0;
        scanall      = 1'b0;
        sprites      = '0;
        frames_done  = 0;
        rng          = 32'h580d_7aeb;
        draw_sprites();
        run_cycles(16);
        rst = 1'b0;
        // FULL_0 then FULL_1
        wait_frames(2);
        // three sprite scan frames
        wait_frames(2);
        scanall = 1'b1;
        wait_frames(1);
        scanall = 1'b0;
        wait_frames(2);
        // reset pulse inside the sprite windows
        run_cycles(1200);
        rst = 1'b1;
        run_cycles(2);
        rst = 1'b0;
        wait_frames(1);
        wait_frames(2);
        run_cycles(8);
        if (dut_i.chk_i.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "checker reported failures");
        end
    end

endmodule

// File: tests/frame_scan_chk.sv
// -----------------------------------------------
// frame scan checker: reference model of regions,
// steps and addresses with concurrent assertions
// -----------------------------------------------
`timescale 1ns/1ps
`include "scan_cfg.svh"

module frame_scan_chk
    import scan_pkg::*;
(
    input logic        vgaclk,
    input logic        rst,
    input logic [9:0]  hc,
    input logic [9:0]  vc,
    input logic        write_enable,
    input logic        scanall,
    input sprite_set_t sprites,
    input logic [8:0]  xpos,
    input logic [8:0]  ypos,
    input logic [15:0] address
);

    // scan frame boundaries, counted in steps from the frame end
    localparam int SPRITE_END  = 2 * `NUM_SPRITES * `SPRITE_STEPS;
    localparam int PELLET_END  = SPRITE_END + 256;
    localparam int SCORE_END   = PELLET_END + `SCORE_STEPS;
    localparam int SCAN_END    = SCORE_END + `TEXT_STEPS;
    localparam int SCORE_CELLS = `SCORE_W * `SCORE_H;

    int unsigned fail_count;
    bit          armed;
    logic        rst_q;
    logic        full;
    logic        second;
    int          k;
    logic        frame_end;
    sprite_set_t m_cur;
    sprite_set_t m_bank [2];
    scan_point_t exp_now;
    scan_point_t exp_q1;
    scan_point_t exp_q2;
    logic [15:0] exp_addr;

    function automatic logic [15:0] addr_rule(logic [8:0] x, logic [8:0] y);
        int ax;
        int ay;
        ax = int'(x);
        ay = int'(y);
        if (ay >= `MAZE_Y0 && ay < `MAZE_Y0 + `MAZE_H) begin
            return 16'(ax + (ay - `MAZE_Y0) * `SCR_W);
        end
        if (ay >= `SCORE_Y0 && ay < `SCORE_Y0 + `SCORE_H
                && ax >= `SCORE_X0 && ax < `SCORE_X0 + `SCORE_W) begin
            return 16'(`SCORE_ADDR0 + ax + (ay - `SCORE_Y0) * `SCORE_W);
        end
        if (ay >= `LIVES_Y0 && ay < `LIVES_Y0 + `LIVES_H
                && ax >= `LIVES_X0 && ax < `LIVES_X0 + `LIVES_W) begin
            return 16'(`SCORE_ADDR0 + SCORE_CELLS + ax + (ay - `LIVES_Y0) * `LIVES_W);
        end
        return 16'(`ADDR_NONE);
    endfunction

    assign frame_end = (hc == 10'(`H_LAST)) && (vc == 10'(`V_LAST));
    assign exp_addr  = rst_q ? 16'd0 : addr_rule(exp_q2.x, exp_q2.y);

    // expected point for the region of this cycle
    always_comb begin
        int          j;
        sprite_pos_t pos;
        j       = 0;
        pos     = '0;
        exp_now = '0;
        if (full) begin
            if (vc < 10'(`V_VISIBLE)) begin
                exp_now.x = 9'(`SCR_W - 1 - int'(vc) / 2);
                exp_now.y = (hc < 10'(`H_VISIBLE)) ? 9'(hc / 2) : 9'(`SCR_H - 1);
            end
        end else if (k < SPRITE_END) begin
            // 512 steps per sprite, old window in the upper half
            j   = k % 256;
            pos = ((k / 256) % 2 == 1) ? m_bank[!write_enable][3'(k / 512)]
                                       : m_cur[3'(k / 512)];
            exp_now.x = 9'(int'(pos.x) + j % 16 - `SPRITE_HALF);
            exp_now.y = 9'(int'(pos.y) + j / 16 - `SPRITE_HALF);
        end else if (k < PELLET_END) begin
            j = k - SPRITE_END;
            exp_now.x = 9'(((j / 64) % 2 == 1 ? `PELLET_HI : `PELLET_LO) + j % 8);
            exp_now.y = 9'((j / 128 == 1 ? `PELLET_Y_HI : `PELLET_Y_LO) + (j / 8) % 8);
        end else if (k < SCORE_END) begin
            j = k - PELLET_END;
            if (j < SCORE_CELLS) begin
                exp_now.x = 9'(`SCORE_X0 + j % `SCORE_W);
                exp_now.y = 9'(`SCORE_Y0 + j / `SCORE_W);
            end else begin
                j = j - SCORE_CELLS;
                exp_now.x = 9'(`LIVES_X0 + j % `LIVES_W);
                exp_now.y = 9'(`LIVES_Y0 + j / `LIVES_W);
            end
        end else if (k < SCAN_END) begin
            j = k - SCORE_END;
            exp_now.x = 9'(`TEXT_X0 + j % `TEXT_W);
            exp_now.y = 9'(`TEXT_Y0 + j / `TEXT_W);
        end
    end

    always_ff @(posedge vgaclk) begin
        armed <= armed | rst;
        rst_q <= rst;
        if (rst) begin
            full      <= 1'b1;
            second    <= 1'b0;
            k         <= 0;
            m_cur     <= '0;
            m_bank[0] <= '0;
            m_bank[1] <= '0;
            exp_q1    <= '0;
            exp_q2    <= '0;
        end else begin
            exp_q1 <= exp_now;
            exp_q2 <= exp_q1;
            if (frame_end) begin
                m_cur <= sprites;
                // bank 0 belongs to write_enable high
                m_bank[!write_enable] <= m_cur;
            end
            if (frame_end && full && !second) begin
                second <= 1'b1;
            end else if (frame_end && (full || k >= SCAN_END)) begin
                full   <= scanall;
                second <= 1'b0;
                k      <= 0;
            end else if (!full && k < SCAN_END) begin
                k <= k + 1;
            end
        end
    end

    xpos_matches: assert property (@(posedge vgaclk) armed |-> xpos == exp_q2.x)
        else begin
            $error("ERROR %0t xpos got %0d expected %0d", $time, $sampled(xpos),
                   $sampled(exp_q2.x));
            fail_count++;
        end

    ypos_matches: assert property (@(posedge vgaclk) armed |-> ypos == exp_q2.y)
        else begin
            $error("ERROR %0t ypos got %0d expected %0d", $time, $sampled(ypos),
                   $sampled(exp_q2.y));
            fail_count++;
        end

    address_matches: assert property (@(posedge vgaclk) armed |-> address == exp_addr)
        else begin
            $error("ERROR %0t address got %0d expected %0d", $time, $sampled(address),
                   $sampled(exp_addr));
            fail_count++;
        end

    reset_clears: assert property (@(posedge vgaclk) rst |-> ##2 (xpos == 9'd0 && ypos == 9'd0))
        else begin
            $error("outputs were not cleared two cycles after reset at %0t", $time);
            fail_count++;
        end

endmodule

// File: hw/frame_scan_top.sv
// -----------------------------------------------
// frame scan top: latch, sequencer and address
// map as a three-stage pipeline
// -----------------------------------------------
`timescale 1ns/1ps
`include "scan_cfg.svh"

module frame_scan_top
    import scan_pkg::*;
(
    input  logic        vgaclk,
    input  logic        rst,
    input  logic [9:0]  hc,
    input  logic [9:0]  vc,
    input  logic        write_enable,
    input  logic        scanall,
    input  sprite_set_t sprites,
    output logic [8:0]  xpos,
    output logic [8:0]  ypos,
    output logic [15:0] address
);

    logic        frame_end;
    sprite_set_t cur_set;
    sprite_set_t prev_set;
    scan_point_t seq_point;
    scan_point_t map_point;

    // snapshot strobe for the latch
    assign frame_end = (hc == 10'(`H_LAST)) && (vc == 10'(`V_LAST));

    sprite_latch latch_i (
        .vgaclk       (vgaclk),
        .rst          (rst),
        .frame_end    (frame_end),
        .write_enable (write_enable),
        .sprites      (sprites),
        .cur          (cur_set),
        .prev         (prev_set)
    );

    scan_sequencer seq_i (
        .vgaclk  (vgaclk),
        .rst     (rst),
        .hc      (hc),
        .vc      (vc),
        .scanall (scanall),
        .cur     (cur_set),
        .prev    (prev_set),
        .point   (seq_point)
    );

    frame_addr_map map_i (
        .vgaclk    (vgaclk),
        .rst       (rst),
        .point_in  (seq_point),
        .point_out (map_point),
        .address   (address)
    );

    assign xpos = map_point.x;
    assign ypos = map_point.y;

endmodule

// File: hw/frame_addr_map.sv
// -----------------------------------------------
// frame address map: scan point to ping-pong
// buffer address, registered with its point
// -----------------------------------------------
`timescale 1ns/1ps
`include "scan_cfg.svh"

module frame_addr_map
    import scan_pkg::*;
(
    input  logic        vgaclk,
    input  logic        rst,
    input  scan_point_t point_in,
    output scan_point_t point_out,
    output logic [15:0] address
);

    logic [15:0] px;
    logic [15:0] py;
    logic        in_maze;
    logic        in_score;
    logic        in_lives;
    logic [15:0] address_d;

    assign px = 16'(point_in.x);
    assign py = 16'(point_in.y);

    assign in_maze = (py >= 16'(`MAZE_Y0)) && (py < 16'(`MAZE_Y0 + `MAZE_H));

    assign in_score = (py >= 16'(`SCORE_Y0)) && (py < 16'(`SCORE_Y0 + `SCORE_H))
                   && (px >= 16'(`SCORE_X0)) && (px < 16'(`SCORE_X0 + `SCORE_W));

    assign in_lives = (py >= 16'(`LIVES_Y0)) && (py < 16'(`LIVES_Y0 + `LIVES_H))
                   && (px >= 16'(`LIVES_X0)) && (px < 16'(`LIVES_X0 + `LIVES_W));

    // maze band wins over the strips
    always_comb begin
        if (in_maze) begin
            address_d = px + (py - 16'(`MAZE_Y0)) * 16'(`SCR_W);
        end else if (in_score) begin
            address_d = 16'(`SCORE_ADDR0) + px + (py - 16'(`SCORE_Y0)) * 16'(`SCORE_W);
        end else if (in_lives) begin
            // lives area follows the score cells
            address_d = 16'(`SCORE_ADDR0 + `SCORE_W * `SCORE_H) + px
                      + (py - 16'(`LIVES_Y0)) * 16'(`LIVES_W);
        end else begin
            address_d = 16'(`ADDR_NONE);
        end
    end

    always_ff @(posedge vgaclk) begin
        if (rst) begin
            point_out <= '0;
            address   <= '0;
        end else begin
            point_out <= point_in;
            address   <= address_d;
        end
    end

endmodule

// File: hw/scan_sequencer.sv
// -----------------------------------------------
// scan sequencer: region FSM and step counter,
// one registered scan point per cycle
// -----------------------------------------------
`timescale 1ns/1ps
`include "scan_cfg.svh"

module scan_sequencer
    import scan_pkg::*;
(
    input  logic        vgaclk,
    input  logic        rst,
    input  logic [9:0]  hc,
    input  logic [9:0]  vc,
    input  logic        scanall,
    input  sprite_set_t cur,
    input  sprite_set_t prev,
    output scan_point_t point
);

    localparam int SCORE_CELLS = `SCORE_W * `SCORE_H;

    scan_state_t state;
    scan_state_t state_d;
    logic [2:0]  sprite_idx;
    logic [2:0]  sprite_idx_d;
    logic [10:0] step;
    logic [10:0] step_d;
    logic [10:0] lives_step;
    logic        step_last;
    logic        frame_end;
    sprite_pos_t win_pos;
    scan_point_t point_d;

    assign frame_end  = (hc == 10'(`H_LAST)) && (vc == 10'(`V_LAST));
    assign win_pos    = (state == SPRITE_OLD) ? prev[sprite_idx] : cur[sprite_idx];
    assign lives_step = step - 11'(SCORE_CELLS);

    // pellet pass has the same length as a sprite window
    always_comb begin
        case (state)
            SPRITE_NEW, SPRITE_OLD, PELLET: step_last = (step == 11'(`SPRITE_STEPS - 1));
            SCORE:   step_last = (step == 11'(`SCORE_STEPS - 1));
            TEXT:    step_last = (step == 11'(`TEXT_STEPS - 1));
            default: step_last = 1'b0;
        endcase
    end

    always_comb begin
        state_d      = state;
        sprite_idx_d = sprite_idx;
        step_d       = step_last ? 11'd0 : step + 11'd1;
        case (state)
            FULL_0: begin
                step_d = '0;
                if (frame_end) begin
                    state_d = FULL_1;
                end
            end
            FULL_1, IDLE: begin
                step_d = '0;
                if (frame_end) begin
                    state_d      = scanall ? FULL_0 : SPRITE_NEW;
                    sprite_idx_d = '0;
                end
            end
            SPRITE_NEW: begin
                if (step_last) begin
                    state_d = SPRITE_OLD;
                end
            end
            SPRITE_OLD: begin
                if (step_last && sprite_idx == 3'(`NUM_SPRITES - 1)) begin
                    state_d = PELLET;
                end else if (step_last) begin
                    state_d      = SPRITE_NEW;
                    sprite_idx_d = sprite_idx + 3'd1;
                end
            end
            PELLET: begin
                if (step_last) begin
                    state_d = SCORE;
                end
            end
            SCORE: begin
                if (step_last) begin
                    state_d = TEXT;
                end
            end
            TEXT: begin
                if (step_last) begin
                    state_d = IDLE;
                end
            end
            default: state_d = FULL_0;
        endcase
    end

    // point for the current state and step
    always_comb begin
        point_d = '0;
        case (state)
            FULL_0, FULL_1: begin
                // off-screen lines stay at (0,0)
                if (vc < 10'(`V_VISIBLE)) begin
                    point_d.x = 9'(`SCR_W - 1) - vc[9:1];
                    point_d.y = (hc < 10'(`H_VISIBLE)) ? hc[9:1] : 9'(`SCR_H - 1);
                end
            end
            SPRITE_NEW, SPRITE_OLD: begin
                point_d.x = win_pos.x - 9'(`SPRITE_HALF) + 9'(step[3:0]);
                point_d.y = win_pos.y - 9'(`SPRITE_HALF) + 9'(step[7:4]);
            end
            PELLET: begin
                point_d.x = (step[6] ? 9'(`PELLET_HI) : 9'(`PELLET_LO)) + 9'(step[2:0]);
                point_d.y = (step[7] ? 9'(`PELLET_Y_HI) : 9'(`PELLET_Y_LO)) + 9'(step[5:3]);
            end
            SCORE: begin
                if (step < 11'(SCORE_CELLS)) begin
                    point_d.x = 9'(`SCORE_X0 + step % `SCORE_W);
                    point_d.y = 9'(`SCORE_Y0 + step / `SCORE_W);
                end else begin
                    point_d.x = 9'(`LIVES_X0 + lives_step % `LIVES_W);
                    point_d.y = 9'(`LIVES_Y0 + lives_step / `LIVES_W);
                end
            end
            TEXT: begin
                point_d.x = 9'(`TEXT_X0 + step % `TEXT_W);
                point_d.y = 9'(`TEXT_Y0 + step / `TEXT_W);
            end
            default: point_d = '0;
        endcase
    end

    always_ff @(posedge vgaclk) begin
        if (rst) begin
            state      <= FULL_0;
            sprite_idx <= '0;
            step       <= '0;
            point      <= '0;
        end else begin
            state      <= state_d;
            sprite_idx <= sprite_idx_d;
            step       <= step_d;
            point      <= point_d;
        end
    end

endmodule

// File: hw/sprite_latch.sv
// -----------------------------------------------
// sprite latch: frame-end position snapshot with
// one previous-position bank per buffer
// -----------------------------------------------
`timescale 1ns/1ps
`include "scan_cfg.svh"

module sprite_latch
    import scan_pkg::*;
(
    input  logic        vgaclk,
    input  logic        rst,
    input  logic        frame_end,
    input  logic        write_enable,
    input  sprite_set_t sprites,
    output sprite_set_t cur,
    output sprite_set_t prev
);

    sprite_set_t prev_bank0;
    sprite_set_t prev_bank1;

    always_ff @(posedge vgaclk) begin
        if (rst) begin
            cur        <= '0;
            prev_bank0 <= '0;
            prev_bank1 <= '0;
        end else if (frame_end) begin
            cur <= sprites;
            // the bank being written keeps where it last drew
            if (write_enable) begin
                prev_bank0 <= cur;
            end else begin
                prev_bank1 <= cur;
            end
        end
    end

    // erase positions for the bank in use
    always_comb begin
        for (int i = 0; i < `NUM_SPRITES; i++) begin
            if (write_enable) begin
                prev[i] = prev_bank0[i];
            end else begin
                prev[i] = prev_bank1[i];
            end
        end
    end

endmodule

// File: hw/scan_pkg.sv
// -----------------------------------------------
// frame scan types: sprite positions, scan points
// and the scan region states
// -----------------------------------------------
`include "scan_cfg.svh"

package scan_pkg;

    // centre of one sprite
    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
    } sprite_pos_t;

    // one buffer pixel coordinate
    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
    } scan_point_t;

    typedef enum logic [2:0] {
        FULL_0,
        FULL_1,
        SPRITE_NEW,
        SPRITE_OLD,
        PELLET,
        SCORE,
        TEXT,
        IDLE
    } scan_state_t;

    // index 0 is pacman, then blinky, pinky, inky, clyde
    typedef sprite_pos_t [`NUM_SPRITES-1:0] sprite_set_t;

endpackage

// File: hw/scan_cfg.svh
// -----------------------------------------------
// frame scan constants: raster, screen regions,
// step counts and frame-buffer address bases
// -----------------------------------------------
`ifndef SCAN_CFG_SVH
`define SCAN_CFG_SVH

// rotated screen in buffer pixels
`define SCR_W        240
`define SCR_H        320

// raster timing
`define H_VISIBLE    640
`define V_VISIBLE    480
`define H_LAST       799
`define V_LAST       524

// 16x16 sprite window around the centre
`define SPRITE_HALF  7
`define SPRITE_STEPS 256
`define NUM_SPRITES  5

// maze band, tiles 3 to 35
`define MAZE_Y0      24
`define MAZE_H       264

`define SCORE_X0     8
`define SCORE_Y0     8
`define SCORE_W      56
`define SCORE_H      8

`define LIVES_X0     8
`define LIVES_Y0     296
`define LIVES_W      80
`define LIVES_H      16

`define TEXT_X0      80
`define TEXT_Y0      176
`define TEXT_W       80

// power pellet tile corners
`define PELLET_LO    8
`define PELLET_HI    224
`define PELLET_Y_LO  56
`define PELLET_Y_HI  224

`define SCORE_ADDR0  63360
`define SCORE_STEPS  1728
`define TEXT_STEPS   640
`define ADDR_NONE    65535

`endif
